// ==== project.f ====
+incdir+rtl
rtl/mvt_pkg.sv
rtl/kernel_ram.sv
rtl/mvt_kernel.sv
rtl/xor_fold.sv
rtl/mvt_top.sv
test/tb_clock.sv
test/mvt_tb.sv

// ==== rtl/kernel_ram.sv ====
`timescale 1ns/1ps
`include "mvt_settings.svh"

module kernel_ram #(
    parameter mvt_pkg::ram_id_t RAM_ID = mvt_pkg::RAM_A,
    parameter int               DEPTH  = `MVT_N * `MVT_N
) (
    input  logic                   ap_clk,
    input  logic                   arst_n,
    input  logic                   ap_done,
    input  logic                   kram_en,
    input  logic [`MVT_MAT_AW-1:0] kram_addr,
    output logic [`MVT_DATA_W-1:0] kram_dout
);

    import mvt_pkg::*;

    localparam int AW    = $clog2(DEPTH);
    localparam int DS_W  = $clog2(`MVT_DATASET_NUM);
    localparam int RUN_W = $clog2(`MVT_UPDATE_INV + 1);

    logic [`MVT_DATA_W-1:0] rom [0:`MVT_DATASET_NUM*DEPTH-1];
    logic [DS_W-1:0]        dataset_sel;
    logic [RUN_W-1:0]       run_cnt;

    // ######################################################################
    // contents for every dataset, laid out dataset after dataset
    // ######################################################################
    initial
    begin
        for (int d = 0; d < `MVT_DATASET_NUM; d++)
        begin
            for (int k = 0; k < DEPTH; k++)
            begin
                rom[d*DEPTH + k] = kram_content(RAM_ID, d, k);
            end
        end
    end

    // run counter, selector moves every UPDATE_INV completed runs
    always_ff @(posedge ap_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            run_cnt     <= '0;
            dataset_sel <= '0;
        end
        else if (ap_done)
        begin
            if (run_cnt == RUN_W'(`MVT_UPDATE_INV - 1))
            begin
                run_cnt <= '0;
                // wraps after the last dataset
                if (dataset_sel == DS_W'(`MVT_DATASET_NUM - 1))
                    dataset_sel <= '0;
                else
                    dataset_sel <= dataset_sel + 1'b1;
            end
            else
            begin
                run_cnt <= run_cnt + 1'b1;
            end
        end
    end

    // registered read, output holds without enable
    always_ff @(posedge ap_clk)
    begin
        if (kram_en)
            kram_dout <= rom[{dataset_sel, kram_addr[AW-1:0]}];
    end

endmodule

// ==== rtl/mvt_kernel.sv ====
`timescale 1ns/1ps
`include "mvt_settings.svh"

module mvt_kernel (
    input  logic                    ap_clk,
    input  logic                    arst_n,
    input  logic                    ap_start,
    output logic                    ap_done,
    output logic                    ap_idle,
    output logic                    a_en,
    output logic [`MVT_MAT_AW-1:0]  a_addr,
    input  logic [`MVT_DATA_W-1:0]  a_q,
    output logic                    x1_en,
    output logic [`MVT_VEC_AW-1:0]  x1_addr,
    input  logic [`MVT_DATA_W-1:0]  x1_q,
    output logic                    x2_en,
    output logic [`MVT_VEC_AW-1:0]  x2_addr,
    input  logic [`MVT_DATA_W-1:0]  x2_q,
    output logic                    y1_en,
    output logic [`MVT_VEC_AW-1:0]  y1_addr,
    input  logic [`MVT_DATA_W-1:0]  y1_q,
    output logic                    y2_en,
    output logic [`MVT_VEC_AW-1:0]  y2_addr,
    input  logic [`MVT_DATA_W-1:0]  y2_q,
    output mvt_pkg::kernel_result_t result
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_ROW_RD,
        S_ROW_LD,
        S_ACC0,
        S_ACC1,
        S_DRAIN,
        S_WRITE,
        S_DONE
    } state_t;

    localparam logic [`MVT_VEC_AW-1:0] LAST_IDX = `MVT_VEC_AW'(`MVT_N - 1);

    state_t                 state;
    logic [`MVT_VEC_AW-1:0] row;
    logic [`MVT_VEC_AW-1:0] col;
    logic                   mul2_vld;
    logic [`MVT_DATA_W-1:0] acc1;
    logic [`MVT_DATA_W-1:0] acc2;
    logic [`MVT_DATA_W-1:0] prod1;
    logic [`MVT_DATA_W-1:0] prod2;

    // ######################################################################
    // control FSM, rows outer, j inner with two sub-steps
    // ######################################################################
    always_ff @(posedge ap_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= S_IDLE;
            row      <= '0;
            col      <= '0;
            mul2_vld <= 1'b0;
        end
        else
        begin
            // sub-step 1 read returns one cycle later
            mul2_vld <= (state == S_ACC1);
            case (state)
                S_IDLE:
                begin
                    row <= '0;
                    col <= '0;
                    if (ap_start)
                        state <= S_ROW_RD;
                end
                S_ROW_RD: state <= S_ROW_LD;
                S_ROW_LD: state <= S_ACC0;
                S_ACC0:   state <= S_ACC1;
                S_ACC1:
                begin
                    if (col == LAST_IDX)
                    begin
                        col   <= '0;
                        state <= S_DRAIN;
                    end
                    else
                    begin
                        col   <= col + 1'b1;
                        state <= S_ACC0;
                    end
                end
                S_DRAIN:  state <= S_WRITE;
                S_WRITE:
                begin
                    if (row == LAST_IDX)
                    begin
                        row   <= '0;
                        state <= S_DONE;
                    end
                    else
                    begin
                        row   <= row + 1'b1;
                        state <= S_ROW_RD;
                    end
                end
                default:  state <= S_IDLE;
            endcase
        end
    end

    // memory read ports
    assign x1_en   = (state == S_ROW_RD);
    assign x2_en   = (state == S_ROW_RD);
    assign x1_addr = row;
    assign x2_addr = row;
    assign y1_en   = (state == S_ACC0);
    assign y2_en   = (state == S_ACC1);
    assign y1_addr = col;
    assign y2_addr = col;
    assign a_en    = (state == S_ACC0) || (state == S_ACC1);
    // N is a power of two, so i*N+j is a plain concatenation
    assign a_addr  = (state == S_ACC1) ? {col, row} : {row, col};

    // ######################################################################
    // accumulators, wrapping 32-bit arithmetic
    // ######################################################################
    assign prod1 = a_q * y1_q;
    assign prod2 = a_q * y2_q;

    always_ff @(posedge ap_clk)
    begin
        if (state == S_ROW_LD)
        begin
            acc1 <= x1_q;
            acc2 <= x2_q;
        end
        else
        begin
            // A[i][j]*y1[j] lands during sub-step 1
            if (state == S_ACC1)
                acc1 <= acc1 + prod1;
            // A[j][i]*y2[j] lands one cycle after sub-step 1
            if (mul2_vld)
                acc2 <= acc2 + prod2;
        end
    end

    assign result.x1_out = acc1;
    assign result.x2_out = acc2;
    assign result.write  = (state == S_WRITE);

    assign ap_done = (state == S_DONE);
    assign ap_idle = (state == S_IDLE);

endmodule

// ==== rtl/mvt_pkg.sv ====
`include "mvt_settings.svh"

package mvt_pkg;

    // memory identity, order gives the memory number
    typedef enum logic [2:0] {
        RAM_A,
        RAM_X1,
        RAM_X2,
        RAM_Y1,
        RAM_Y2
    } ram_id_t;

    // both results of one row plus the write strobe
    typedef struct packed {
        logic [`MVT_DATA_W-1:0] x1_out;
        logic [`MVT_DATA_W-1:0] x2_out;
        logic                   write;
    } kernel_result_t;

    // one result word, whole or split into bytes for folding
    typedef union packed {
        logic [`MVT_DATA_W-1:0] word;
        logic [3:0][7:0]        bytes;
    } result_word_u;

    // stored word for a memory, a dataset and an index
    function automatic logic [`MVT_DATA_W-1:0] kram_content(input ram_id_t     id,
                                                            input int unsigned dataset,
                                                            input int unsigned index);
        logic [31:0] acc;
        acc = index * 32'h9E3779B1;
        acc = acc + 32'(id) * 32'h01000193;
        acc = acc + dataset * 32'h0000B5A5;
        acc = acc ^ (index << 11);
        return acc;
    endfunction

endpackage

// ==== rtl/mvt_settings.svh ====
`ifndef MVT_SETTINGS_SVH
`define MVT_SETTINGS_SVH

// matrix dimension, square matrix A
`define MVT_N           8

// data word width
`define MVT_DATA_W      32

// datasets held per memory
`define MVT_DATASET_NUM 4

// completed runs per dataset advance
`define MVT_UPDATE_INV  1

// address widths, clog2 of N*N and of N
`define MVT_MAT_AW      6
`define MVT_VEC_AW      3

`endif

// ==== rtl/mvt_top.sv ====
`timescale 1ns/1ps
`include "mvt_settings.svh"

module mvt_top (
    input  logic       ap_clk,
    input  logic       arst_n,
    input  logic       ap_start,
    output logic       ap_done,
    output logic       ap_idle,
    output logic [3:0] data_out,
    output logic       data_valid
);

    import mvt_pkg::*;

    localparam int PAD_W = `MVT_MAT_AW - `MVT_VEC_AW;

    logic                   a_en;
    logic [`MVT_MAT_AW-1:0] a_addr;
    logic [`MVT_DATA_W-1:0] a_q;
    logic                   x1_en;
    logic [`MVT_VEC_AW-1:0] x1_addr;
    logic [`MVT_DATA_W-1:0] x1_q;
    logic                   x2_en;
    logic [`MVT_VEC_AW-1:0] x2_addr;
    logic [`MVT_DATA_W-1:0] x2_q;
    logic                   y1_en;
    logic [`MVT_VEC_AW-1:0] y1_addr;
    logic [`MVT_DATA_W-1:0] y1_q;
    logic                   y2_en;
    logic [`MVT_VEC_AW-1:0] y2_addr;
    logic [`MVT_DATA_W-1:0] y2_q;
    kernel_result_t         result;

    // ######################################################################
    // dataset memories
    // ######################################################################
    kernel_ram #(.RAM_ID(RAM_A), .DEPTH(`MVT_N * `MVT_N)) i_a_ram (
        .ap_clk(ap_clk), .arst_n(arst_n), .ap_done(ap_done),
        .kram_en(a_en), .kram_addr(a_addr), .kram_dout(a_q)
    );

    // vector memories, address zero-extended to the port width
    kernel_ram #(.RAM_ID(RAM_X1), .DEPTH(`MVT_N)) i_x1_ram (
        .ap_clk(ap_clk), .arst_n(arst_n), .ap_done(ap_done),
        .kram_en(x1_en), .kram_addr({{PAD_W{1'b0}}, x1_addr}), .kram_dout(x1_q)
    );

    kernel_ram #(.RAM_ID(RAM_X2), .DEPTH(`MVT_N)) i_x2_ram (
        .ap_clk(ap_clk), .arst_n(arst_n), .ap_done(ap_done),
        .kram_en(x2_en), .kram_addr({{PAD_W{1'b0}}, x2_addr}), .kram_dout(x2_q)
    );

    kernel_ram #(.RAM_ID(RAM_Y1), .DEPTH(`MVT_N)) i_y1_ram (
        .ap_clk(ap_clk), .arst_n(arst_n), .ap_done(ap_done),
        .kram_en(y1_en), .kram_addr({{PAD_W{1'b0}}, y1_addr}), .kram_dout(y1_q)
    );

    kernel_ram #(.RAM_ID(RAM_Y2), .DEPTH(`MVT_N)) i_y2_ram (
        .ap_clk(ap_clk), .arst_n(arst_n), .ap_done(ap_done),
        .kram_en(y2_en), .kram_addr({{PAD_W{1'b0}}, y2_addr}), .kram_dout(y2_q)
    );

    // ######################################################################
    // kernel and signature fold
    // ######################################################################
    mvt_kernel i_mvt_kernel (
        .ap_clk(ap_clk), .arst_n(arst_n), .ap_start(ap_start),
        .ap_done(ap_done), .ap_idle(ap_idle),
        .a_en(a_en), .a_addr(a_addr), .a_q(a_q),
        .x1_en(x1_en), .x1_addr(x1_addr), .x1_q(x1_q),
        .x2_en(x2_en), .x2_addr(x2_addr), .x2_q(x2_q),
        .y1_en(y1_en), .y1_addr(y1_addr), .y1_q(y1_q),
        .y2_en(y2_en), .y2_addr(y2_addr), .y2_q(y2_q),
        .result(result)
    );

    xor_fold i_xor_fold (
        .ap_clk(ap_clk), .arst_n(arst_n), .result(result),
        .data_out(data_out), .data_valid(data_valid)
    );

endmodule

// ==== rtl/xor_fold.sv ====
`timescale 1ns/1ps
`include "mvt_settings.svh"

module xor_fold (
    input  logic                    ap_clk,
    input  logic                    arst_n,
    input  mvt_pkg::kernel_result_t result,
    output logic [3:0]              data_out,
    output logic                    data_valid
);

    import mvt_pkg::*;

    result_word_u w1;
    result_word_u w2;
    logic [7:0]   xor_1 [2];
    logic [1:0]   valid_1;
    logic [7:0]   xor_2;
    logic         valid_2;

    assign w1.word = result.x1_out;
    assign w2.word = result.x2_out;

    // ######################################################################
    // valid pipeline, one bit per lane then merged
    // ######################################################################
    always_ff @(posedge ap_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            valid_1    <= '0;
            valid_2    <= 1'b0;
            data_valid <= 1'b0;
        end
        else
        begin
            valid_1    <= {result.write, result.write};
            valid_2    <= |valid_1;
            data_valid <= valid_2;
        end
    end

    always_ff @(posedge ap_clk)
    begin
        // stage 1, bytes of each word
        xor_1[1] <= w1.bytes[0] ^ w1.bytes[1] ^ w1.bytes[2] ^ w1.bytes[3];
        xor_1[0] <= w2.bytes[0] ^ w2.bytes[1] ^ w2.bytes[2] ^ w2.bytes[3];
        // stage 2, select or merge by lane valid
        case (valid_1)
            2'b01:   xor_2 <= xor_1[0];
            2'b10:   xor_2 <= xor_1[1];
            2'b11:   xor_2 <= xor_1[0] ^ xor_1[1];
            default: xor_2 <= '0;
        endcase
        // stage 3, nibble fold
        data_out <= xor_2[7:4] ^ xor_2[3:0];
    end

endmodule

// ==== test/mvt_tb.sv ====
`timescale 1ns/1ps
`include "mvt_settings.svh"

module mvt_tb;

    localparam int N           = `MVT_N;
    localparam int RUNS        = 12;
    localparam int GAP_RUNS    = 5;
    localparam int CYCLE_LIMIT = (RUNS + 2) * N * (2 * N + 8) + 200;

    // memory numbers used by the content formula
    localparam int MEM_A  = 0;
    localparam int MEM_X1 = 1;
    localparam int MEM_X2 = 2;
    localparam int MEM_Y1 = 3;
    localparam int MEM_Y2 = 4;

    typedef struct packed {
        logic [3:0] sig;
        logic [7:0] dataset;
        logic [7:0] row;
    } expect_t;

    logic       ap_clk;
    logic       arst_n = 1'b0;
    logic       ap_start = 1'b0;
    logic       ap_done;
    logic       ap_idle;
    logic [3:0] data_out;
    logic       data_valid;

    expect_t    exp_q[$];
    expect_t    exp_item;
    int         error_cnt = 0;
    int         check_cnt = 0;
    int         valid_cnt = 0;
    int         done_cnt = 0;
    int         cycle_cnt = 0;
    int         test_cnt = 0;
    int         run_idx = 0;
    int         seed = 34128;

    tb_clock i_tb_clock (.ap_clk(ap_clk));

    mvt_top i_mvt_top (
        .ap_clk(ap_clk), .arst_n(arst_n), .ap_start(ap_start),
        .ap_done(ap_done), .ap_idle(ap_idle),
        .data_out(data_out), .data_valid(data_valid)
    );

    // ######################################################################
    // reference model
    // ######################################################################
    function automatic logic [31:0] mem_word(input int mem, input int dataset, input int index);
        logic [31:0] w;
        w = 32'(index) * 32'h9E3779B1;
        w = w + 32'(mem) * 32'h01000193;
        w = w + 32'(dataset) * 32'h0000B5A5;
        w = w ^ (32'(index) << 11);
        return w;
    endfunction

    // both row results folded to the 4-bit signature
    function automatic logic [3:0] row_signature(input int dataset, input int row);
        logic [31:0] r1;
        logic [31:0] r2;
        logic [7:0]  b;
        r1 = mem_word(MEM_X1, dataset, row);
        r2 = mem_word(MEM_X2, dataset, row);
        for (int j = 0; j < N; j++)
        begin
            r1 = r1 + mem_word(MEM_A, dataset, row * N + j) * mem_word(MEM_Y1, dataset, j);
            r2 = r2 + mem_word(MEM_A, dataset, j * N + row) * mem_word(MEM_Y2, dataset, j);
        end
        b = r1[7:0] ^ r1[15:8] ^ r1[23:16] ^ r1[31:24];
        b = b ^ r2[7:0] ^ r2[15:8] ^ r2[23:16] ^ r2[31:24];
        return b[7:4] ^ b[3:0];
    endfunction

    // ######################################################################
    // helpers
    // ######################################################################
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_cnt++;
        assert (got === exp)
        else
        begin
            error_cnt++;
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_cnt++;
        $display("test %0d %s: %0d errors", test_cnt, name, error_cnt - errors_before);
    endtask

    task automatic apply_reset();
        @(negedge ap_clk);
        arst_n   = 1'b0;
        ap_start = 1'b0;
        repeat (16) @(negedge ap_clk);
        arst_n  = 1'b1;
        run_idx = 0;
    endtask

    // dataset of the next run follows the completed run count
    task automatic queue_run();
        int ds;
        ds = (run_idx / `MVT_UPDATE_INV) % `MVT_DATASET_NUM;
        for (int i = 0; i < N; i++)
        begin
            exp_item.sig     = row_signature(ds, i);
            exp_item.dataset = 8'(ds);
            exp_item.row     = 8'(i);
            exp_q.push_back(exp_item);
        end
        run_idx++;
    endtask

    task automatic wait_done();
        do
            @(negedge ap_clk);
        while (!ap_done);
    endtask

    task automatic drain_rows();
        while (exp_q.size() != 0)
            @(negedge ap_clk);
    endtask

    // one run started by a single-cycle ap_start pulse
    task automatic run_pulsed();
        int valid_before;
        int done_before;
        valid_before = valid_cnt;
        done_before  = done_cnt;
        queue_run();
        @(negedge ap_clk);
        ap_start = 1'b1;
        @(negedge ap_clk);
        ap_start = 1'b0;
        wait_done();
        drain_rows();
        check_value("ap_done count", done_cnt - done_before, 1);
        check_value("data_valid count", valid_cnt - valid_before, N);
    endtask

    // ######################################################################
    // monitor and timeout
    // ######################################################################
    always @(negedge ap_clk)
    begin
        if (data_valid)
        begin
            valid_cnt++;
            assert (exp_q.size() != 0)
            else
            begin
                error_cnt++;
                $display("data_valid pulsed while no row result was pending");
            end
            if (exp_q.size() != 0)
            begin
                exp_item = exp_q.pop_front();
                check_cnt++;
                assert (data_out === exp_item.sig)
                else
                begin
                    error_cnt++;
                    $display("FAIL data_out: got 0x%h, expected 0x%h (dataset %0d row %0d)",
                             data_out, exp_item.sig, exp_item.dataset, exp_item.row);
                end
            end
        end
        if (ap_done)
            done_cnt++;
    end

    always @(posedge ap_clk)
    begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            $display("run stopped after %0d cycles, the tests did not finish", cycle_cnt);
            $display("Test failures found");
            $finish;
        end
    end

    // ######################################################################
    // test sequence
    // ######################################################################
    initial
    begin
        int errs;
        int valid_before;
        int done_before;
        int gap;

        // idle after reset
        errs = error_cnt;
        apply_reset();
        repeat (20)
        begin
            @(negedge ap_clk);
            check_value("ap_idle", ap_idle, 1);
            check_value("ap_done", ap_done, 0);
            check_value("data_valid", data_valid, 0);
        end
        finish_test("idle after reset", errs);

        // first run on dataset 0
        errs = error_cnt;
        run_pulsed();
        finish_test("first run", errs);

        // four back-to-back runs with start held high
        errs         = error_cnt;
        valid_before = valid_cnt;
        done_before  = done_cnt;
        for (int r = 0; r < 4; r++)
            queue_run();
        @(negedge ap_clk);
        ap_start = 1'b1;
        for (int r = 0; r < 4; r++)
            wait_done();
        ap_start = 1'b0;
        drain_rows();
        check_value("ap_done count", done_cnt - done_before, 4);
        check_value("data_valid count", valid_cnt - valid_before, 4 * N);
        finish_test("back-to-back runs", errs);

        // pulsed runs with random idle gaps
        errs = error_cnt;
        for (int r = 0; r < GAP_RUNS; r++)
        begin
            gap = $unsigned($random(seed)) % 41;
            repeat (gap) @(negedge ap_clk);
            run_pulsed();
        end
        finish_test("runs with idle gaps", errs);

        // reset while a row signature is on the output
        errs         = error_cnt;
        valid_before = valid_cnt;
        queue_run();
        @(negedge ap_clk);
        ap_start = 1'b1;
        @(negedge ap_clk);
        ap_start = 1'b0;
        wait (valid_cnt == valid_before + 3);
        arst_n = 1'b0;
        #1;
        check_value("data_valid", data_valid, 0);
        check_value("ap_done", ap_done, 0);
        check_value("ap_idle", ap_idle, 1);
        exp_q.delete();
        apply_reset();
        run_pulsed();
        finish_test("reset mid-run", errs);

        $display("summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, error_cnt);
        if (error_cnt == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic ap_clk
);

    // 20 ns period
    localparam int HALF_PERIOD = 10;

    initial
    begin
        ap_clk = 1'b0;
    end

    always #(HALF_PERIOD) ap_clk = ~ap_clk;

endmodule
